/* tests/mem_vectors.txt */
// write addr data tag expected (hex)
// expected read data only, unwritten words read as {~addr, addr}
0 0010 00000000 1 FFEF0010
0 0020 00000000 2 FFDF0020
1 0010 DEADBEEF 3 00000000
0 0010 00000000 4 DEADBEEF
0 0030 00000000 5 FFCF0030
1 0020 12345678 6 00000000
1 0020 CAFEF00D 7 00000000
0 0020 00000000 8 CAFEF00D
0 0044 00000000 9 FFBB0044
0 0010 00000000 A DEADBEEF
0 1234 00000000 B EDCB1234
1 0044 0BADC0DE C 00000000
1 0030 A5A55A5A D 00000000
0 0044 00000000 E 0BADC0DE
0 0030 00000000 F A5A55A5A
0 00A8 00000000 0 FF5700A8
1 00A8 11112222 1 00000000
0 00A8 00000000 2 11112222
1 0010 00000001 3 00000000
0 0010 00000000 4 00000001

/* vlog.f */
+incdir+hw
hw/MemoryTypes.sv
hw/MemCommandReceiver.sv
hw/MemRequestQueue.sv
hw/MemoryAccessController.sv
hw/MemAccessSubsystem.sv
tests/MemAccessSubsystem_assertions.sv
tests/MemAccessSubsystem_tb.sv

/* Bender.yml */
package:
  name: mem_access_subsystem

sources:
  - include_dirs:
      - hw
    files:
      - hw/MemoryTypes.sv
      - hw/MemCommandReceiver.sv
      - hw/MemRequestQueue.sv
      - hw/MemoryAccessController.sv
      - hw/MemAccessSubsystem.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/MemAccessSubsystem_assertions.sv
      - tests/MemAccessSubsystem_tb.sv

/* tests/MemAccessSubsystem_tb.sv */
// Testbench for the memory-access subsystem
// Vector-driven command driver, out-of-order memory model, response checker

`timescale 1ns/1ns
`default_nettype none

module MemAccessSubsystem_tb import MemoryTypes::*; ();

    localparam int NumVectors = 20;
    localparam int WordsPerVector = 5;
    localparam int ClockPeriod = 100;
    localparam int InputDelay = 5;

    logic clk = 1'b0;
    logic arstN;
    logic cmdReq, cmdWrite, cmdAck;
    PhyAddrPath cmdAddr;
    MemoryEntryDataPath cmdData;
    MemRequestTag cmdTag;
    PhyAddrPath memAccessAddr;
    MemoryEntryDataPath memAccessWriteData, memReadData;
    logic memAccessRE, memAccessWE, memAccessReadBusy, memAccessWriteBusy;
    MemAccessSerial nextMemReadSerial, memReadSerial;
    MemWriteSerial nextMemWriteSerial, memAccessResponseSerial;
    logic memReadDataReady, memAccessResponseValid;
    logic rspReq, rspAck;
    MemRequestTag rspTag;
    MemoryEntryDataPath rspData;

    // Five words per vector in the order write, addr, data, tag, expected
    logic [31:0] vectorWords [NumVectors*WordsPerVector];
    logic [31:0] lcgState;
    MemRequestTag expTagQ [$];
    MemoryEntryDataPath expDataQ [$];
    int numReads = 0;
    int rspCount = 0;
    int ackCount = 0;
    logic ackSeen = 1'b0;

    // Memory model state
    MemoryEntryDataPath memWords [PhyAddrPath];
    MemAccessSerial pendSerialQ [$];
    MemoryEntryDataPath pendDataQ [$];
    MemWriteSerial writeAckQ [$];

    // Memory starts out busy so the request queue fills up
    int unsigned stallCycles = 40;

    MemAccessSubsystem MemAccessSubsystem_inst (
        .clk(clk), .arstN(arstN),
        .cmdReq(cmdReq), .cmdWrite(cmdWrite), .cmdAddr(cmdAddr),
        .cmdData(cmdData), .cmdTag(cmdTag), .cmdAck(cmdAck),
        .memAccessAddr(memAccessAddr), .memAccessWriteData(memAccessWriteData),
        .memAccessRE(memAccessRE), .memAccessWE(memAccessWE),
        .nextMemReadSerial(nextMemReadSerial), .nextMemWriteSerial(nextMemWriteSerial),
        .memAccessReadBusy(memAccessReadBusy), .memAccessWriteBusy(memAccessWriteBusy),
        .memReadDataReady(memReadDataReady), .memReadData(memReadData),
        .memReadSerial(memReadSerial), .memAccessResponseValid(memAccessResponseValid),
        .memAccessResponseSerial(memAccessResponseSerial),
        .rspReq(rspReq), .rspTag(rspTag), .rspData(rspData), .rspAck(rspAck)
    );

    always #(ClockPeriod / 2) clk = ~clk;

    function automatic int unsigned randomBelow(input int unsigned limit);
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return (lcgState >> 8) % limit;
    endfunction

    // Unwritten words hold a pattern of the whole address
    function automatic MemoryEntryDataPath readWord(input PhyAddrPath addr);
        if (memWords.exists(addr)) begin
            return memWords[addr];
        end
        return {~addr, addr};
    endfunction

    task automatic stopOnError(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic sendCommand(input int index);
        int base;
        base = index * WordsPerVector;
        @(posedge clk);
        repeat (randomBelow(3)) @(posedge clk);
        #InputDelay;
        assert (!cmdAck) else stopOnError("cmdAck was still high when a new request started");
        cmdWrite = vectorWords[base][0];
        cmdAddr = PhyAddrPath'(vectorWords[base+1]);
        cmdData = vectorWords[base+2];
        cmdTag = MemRequestTag'(vectorWords[base+3]);
        if (!cmdWrite) begin
            expTagQ.push_back(cmdTag);
            expDataQ.push_back(vectorWords[base+4]);
        end
        cmdReq = 1'b1;
        do @(negedge clk); while (!cmdAck);
        @(posedge clk);
        #InputDelay cmdReq = 1'b0;
        do @(negedge clk); while (cmdAck);
    endtask

    initial begin
        lcgState = 32'h720ce48e;
        arstN = 1'b0;
        {cmdReq, cmdWrite, cmdAddr, cmdData, cmdTag, rspAck} = '0;
        {nextMemReadSerial, nextMemWriteSerial, memAccessReadBusy, memAccessWriteBusy} = '0;
        {memReadDataReady, memReadData, memReadSerial} = '0;
        {memAccessResponseValid, memAccessResponseSerial} = '0;
        $readmemh("tests/mem_vectors.txt", vectorWords);
        assert (!$isunknown(vectorWords[NumVectors*WordsPerVector-1]))
            else stopOnError("The vector file is missing or holds too few vectors");
        for (int i = 0; i < NumVectors; i++) begin
            if (!vectorWords[i*WordsPerVector][0]) numReads++;
        end
        repeat (2) @(posedge clk);
        #InputDelay arstN = 1'b1;

        // Quiet outputs with no commands
        repeat (4) begin
            @(negedge clk);
            assert (!rspReq && !memAccessRE && !memAccessWE && !cmdAck)
                else stopOnError("An output went active after reset with no input");
        end
        for (int i = 0; i < NumVectors; i++) begin
            sendCommand(i);
        end
        while (rspCount < numReads) @(negedge clk);
        repeat (20) @(negedge clk);
        assert (ackCount == NumVectors) else stopOnError(
            $sformatf("[FAIL] cmdAck count got %h expected %h", ackCount, NumVectors));
        $display("Simulation PASSED");
        $finish;
    end

    always @(negedge clk) begin
        if (cmdAck && !ackSeen) ackCount++;
        ackSeen = cmdAck;
    end

    // Memory model with random busy, out-of-order read returns, late write acks
    always begin
        logic readIssued, writeIssued;
        PhyAddrPath issueAddr;
        MemoryEntryDataPath issueData;
        int unsigned pick;
        @(negedge clk);
        readIssued = arstN && memAccessRE && !memAccessReadBusy;
        writeIssued = arstN && memAccessWE && !memAccessWriteBusy;
        issueAddr = memAccessAddr;
        issueData = memAccessWriteData;
        @(posedge clk);
        #InputDelay;
        memReadDataReady = 1'b0;
        memAccessResponseValid = 1'b0;
        if (readIssued) begin
            pendSerialQ.push_back(nextMemReadSerial);
            pendDataQ.push_back(readWord(issueAddr));
            nextMemReadSerial = nextMemReadSerial + MemAccessSerial'(1);
        end
        if (writeIssued) begin
            memWords[issueAddr] = issueData;
            writeAckQ.push_back(nextMemWriteSerial);
            nextMemWriteSerial = nextMemWriteSerial + MemWriteSerial'(1);
        end
        if (pendSerialQ.size() > 0 && randomBelow(3) == 0) begin
            pick = randomBelow(pendSerialQ.size());
            memReadDataReady = 1'b1;
            memReadSerial = pendSerialQ[pick];
            memReadData = pendDataQ[pick];
            pendSerialQ.delete(pick);
            pendDataQ.delete(pick);
        end
        if (writeAckQ.size() > 0 && randomBelow(4) == 0) begin
            memAccessResponseValid = 1'b1;
            memAccessResponseSerial = writeAckQ.pop_front();
        end
        if (arstN && stallCycles > 0) begin
            stallCycles--;
        end
        memAccessReadBusy = (randomBelow(4) == 0) || (stallCycles > 0);
        memAccessWriteBusy = (randomBelow(4) == 0) || (stallCycles > 0);
    end

    // Response checker with a slow, random rspAck
    always begin
        @(negedge clk);
        if (rspReq) begin
            assert (expTagQ.size() > 0) else stopOnError("A response arrived with no read pending");
            assert (rspTag === expTagQ[0]) else stopOnError(
                $sformatf("[FAIL] rspTag got %h expected %h", rspTag, expTagQ[0]));
            assert (rspData === expDataQ[0]) else stopOnError(
                $sformatf("[FAIL] rspData got %h expected %h", rspData, expDataQ[0]));
            void'(expTagQ.pop_front());
            void'(expDataQ.pop_front());
            rspCount++;
            repeat (randomBelow(4)) @(posedge clk);
            @(posedge clk);
            #InputDelay rspAck = 1'b1;
            do @(negedge clk); while (rspReq);
            @(posedge clk);
            #InputDelay rspAck = 1'b0;
        end
    end

    initial begin
        #(NumVectors * 200 * ClockPeriod);
        stopOnError("Timeout before all commands and responses completed");
    end

endmodule

`default_nettype wire

/* tests/MemAccessSubsystem_assertions.sv */
// Concurrent checks on the response handshake,
// the memory strobes and the command acknowledge

`timescale 1ns/1ns
`default_nettype none

module MemAccessSubsystem_assertions import MemoryTypes::*; (
    input logic               clk,
    input logic               arstN,
    input logic               rspReq,
    input logic               rspAck,
    input MemRequestTag       rspTag,
    input MemoryEntryDataPath rspData,
    input logic               memAccessRE,
    input logic               memAccessWE,
    input logic               cmdReq,
    input logic               cmdAck
);

    rspPayloadStable: assert property (@(posedge clk) disable iff (!arstN)
        (rspReq && !rspAck) |=> ($stable(rspTag) && $stable(rspData)))
        else $error("response payload changed while rspAck was low");

    strobesExclusive: assert property (@(posedge clk) disable iff (!arstN)
        !(memAccessRE && memAccessWE))
        else $error("memAccessRE and memAccessWE high together");

    ackNeedsReq: assert property (@(posedge clk) disable iff (!arstN)
        $rose(cmdAck) |-> cmdReq)
        else $error("cmdAck rose without cmdReq");

endmodule

bind MemoryAccessController MemAccessSubsystem_assertions controllerChecks (
    .clk(clk), .arstN(arstN), .rspReq(rspReq), .rspAck(rspAck),
    .rspTag(rspTag), .rspData(rspData),
    .memAccessRE(memAccessRE), .memAccessWE(memAccessWE),
    .cmdReq(1'b0), .cmdAck(1'b0)
);

bind MemCommandReceiver MemAccessSubsystem_assertions receiverChecks (
    .clk(clk), .arstN(arstN), .rspReq(1'b0), .rspAck(1'b0),
    .rspTag('0), .rspData('0),
    .memAccessRE(1'b0), .memAccessWE(1'b0),
    .cmdReq(cmdReq), .cmdAck(cmdAck)
);

`default_nettype wire

/* hw/MemAccessSubsystem.sv */
// Memory-access subsystem top level
// Command receiver, request queue and access controller

`timescale 1ns/1ns
`default_nettype none

`include "MemAccess_params.svh"

module MemAccessSubsystem import MemoryTypes::*; (
    input  logic               clk,
    input  logic               arstN,

    // Command port
    input  logic               cmdReq,
    input  logic               cmdWrite,
    input  PhyAddrPath         cmdAddr,
    input  MemoryEntryDataPath cmdData,
    input  MemRequestTag       cmdTag,
    output logic               cmdAck,

    // External memory
    output PhyAddrPath         memAccessAddr,
    output MemoryEntryDataPath memAccessWriteData,
    output logic               memAccessRE,
    output logic               memAccessWE,
    input  MemAccessSerial     nextMemReadSerial,
    input  MemWriteSerial      nextMemWriteSerial,
    input  logic               memAccessReadBusy,
    input  logic               memAccessWriteBusy,
    input  logic               memReadDataReady,
    input  MemoryEntryDataPath memReadData,
    input  MemAccessSerial     memReadSerial,
    input  logic               memAccessResponseValid,
    input  MemWriteSerial      memAccessResponseSerial,

    // Response port
    output logic               rspReq,
    output MemRequestTag       rspTag,
    output MemoryEntryDataPath rspData,
    input  logic               rspAck
);

    logic           pushValid;
    MemCommandEntry pushEntry;
    logic           queueFull;
    logic           pop;
    MemCommandEntry popEntry;
    logic           queueEmpty;

    MemCommandReceiver commandReceiver (
        .clk       (clk),
        .arstN     (arstN),
        .cmdReq    (cmdReq),
        .cmdWrite  (cmdWrite),
        .cmdAddr   (cmdAddr),
        .cmdData   (cmdData),
        .cmdTag    (cmdTag),
        .cmdAck    (cmdAck),
        .queueFull (queueFull),
        .pushValid (pushValid),
        .pushEntry (pushEntry)
    );

    MemRequestQueue requestQueue (
        .clk        (clk),
        .arstN      (arstN),
        .pushValid  (pushValid),
        .pushEntry  (pushEntry),
        .queueFull  (queueFull),
        .pop        (pop),
        .popEntry   (popEntry),
        .queueEmpty (queueEmpty)
    );

    MemoryAccessController accessController (
        .clk                     (clk),
        .arstN                   (arstN),
        .popEntry                (popEntry),
        .queueEmpty              (queueEmpty),
        .pop                     (pop),
        .memAccessAddr           (memAccessAddr),
        .memAccessWriteData      (memAccessWriteData),
        .memAccessRE             (memAccessRE),
        .memAccessWE             (memAccessWE),
        .nextMemReadSerial       (nextMemReadSerial),
        .nextMemWriteSerial      (nextMemWriteSerial),
        .memAccessReadBusy       (memAccessReadBusy),
        .memAccessWriteBusy      (memAccessWriteBusy),
        .memReadDataReady        (memReadDataReady),
        .memReadData             (memReadData),
        .memReadSerial           (memReadSerial),
        .memAccessResponseValid  (memAccessResponseValid),
        .memAccessResponseSerial (memAccessResponseSerial),
        .rspReq                  (rspReq),
        .rspTag                  (rspTag),
        .rspData                 (rspData),
        .rspAck                  (rspAck)
    );

endmodule

`default_nettype wire

/* hw/MemoryAccessController.sv */
// Memory access controller
// Issues queued commands to memory, tracks read serials in a reorder table
// and pending writes, returns read results to the core in issue order

`timescale 1ns/1ns
`default_nettype none

`include "MemAccess_params.svh"

module MemoryAccessController import MemoryTypes::*; (
    input  logic               clk,
    input  logic               arstN,

    // Request queue head
    input  MemCommandEntry     popEntry,
    input  logic               queueEmpty,
    output logic               pop,

    // External memory
    output PhyAddrPath         memAccessAddr,
    output MemoryEntryDataPath memAccessWriteData,
    output logic               memAccessRE,
    output logic               memAccessWE,
    input  MemAccessSerial     nextMemReadSerial,
    input  MemWriteSerial      nextMemWriteSerial,
    input  logic               memAccessReadBusy,
    input  logic               memAccessWriteBusy,
    input  logic               memReadDataReady,
    input  MemoryEntryDataPath memReadData,
    input  MemAccessSerial     memReadSerial,
    input  logic               memAccessResponseValid,
    input  MemWriteSerial      memAccessResponseSerial,

    // Response port to the core
    output logic               rspReq,
    output MemRequestTag       rspTag,
    output MemoryEntryDataPath rspData,
    input  logic               rspAck
);

    localparam int unsigned Slots = 1 << `MEM_SERIAL_WIDTH;
    localparam int unsigned WriteCountWidth = $clog2(`MAX_PENDING_WRITES + 1);

    // Unpacked head entry
    logic               headWrite;
    PhyAddrPath         headAddr;
    MemoryEntryDataPath headData;
    MemRequestTag       headTag;

    // Reorder table, indexed by read serial
    MemRequestTag       tagTable [Slots];
    MemoryEntryDataPath dataTable [Slots];
    logic [Slots-1:0]   slotBusy;
    logic [Slots-1:0]   slotFilled;
    MemAccessSerial     headPtr;

    // Write serials still waiting for their response
    logic [Slots-1:0]           writeOutstanding;
    logic [WriteCountWidth-1:0] pendingWrites;
    logic                       writeRoom;

    logic readIssue;
    logic writeIssue;
    logic rspDone;

    AccessCtrlState rspState;
    AccessCtrlState rspStateNext;

    assign {headWrite, headAddr, headData, headTag} = popEntry;

    assign memAccessAddr = headAddr;
    assign memAccessWriteData = headData;

    // Reads wait for their slot to drain, writes for the pending limit
    assign writeRoom = (pendingWrites < WriteCountWidth'(`MAX_PENDING_WRITES)) &&
                       !writeOutstanding[nextMemWriteSerial];
    assign memAccessRE = !queueEmpty && !headWrite && !slotBusy[nextMemReadSerial];
    assign memAccessWE = !queueEmpty && headWrite && writeRoom;

    assign readIssue = memAccessRE && !memAccessReadBusy;
    assign writeIssue = memAccessWE && !memAccessWriteBusy;
    assign pop = readIssue || writeIssue;

    always_ff @(posedge clk) begin
        if (readIssue) begin
            tagTable[nextMemReadSerial] <= headTag;
        end
        if (memReadDataReady) begin
            dataTable[memReadSerial] <= memReadData;
        end
    end

    // Slot allocation, fill and release
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            slotBusy <= '0;
            slotFilled <= '0;
            headPtr <= '0;
        end else begin
            if (readIssue) begin
                slotBusy[nextMemReadSerial] <= 1'b1;
            end
            if (memReadDataReady) begin
                slotFilled[memReadSerial] <= 1'b1;
            end
            if (rspDone) begin
                slotBusy[headPtr] <= 1'b0;
                slotFilled[headPtr] <= 1'b0;
                headPtr <= headPtr + MemAccessSerial'(1);
            end
        end
    end

    // Pending write bookkeeping
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            writeOutstanding <= '0;
            pendingWrites <= '0;
        end else begin
            if (writeIssue) begin
                writeOutstanding[nextMemWriteSerial] <= 1'b1;
            end
            if (memAccessResponseValid) begin
                writeOutstanding[memAccessResponseSerial] <= 1'b0;
            end
            case ({writeIssue, memAccessResponseValid})
                2'b10: pendingWrites <= pendingWrites + 1'b1;
                2'b01: pendingWrites <= pendingWrites - 1'b1;
                default: pendingWrites <= pendingWrites;
            endcase
        end
    end

    // Response FSM, oldest serial first
    always_comb begin
        rspStateNext = rspState;
        unique case (rspState)
            RspIdle: begin
                if (slotFilled[headPtr]) begin
                    rspStateNext = RspWaitAckHigh;
                end
            end
            RspWaitAckHigh: begin
                if (rspAck) begin
                    rspStateNext = RspWaitAckLow;
                end
            end
            RspWaitAckLow: begin
                if (!rspAck) begin
                    rspStateNext = RspIdle;
                end
            end
            default: rspStateNext = RspIdle;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rspState <= RspIdle;
        end else begin
            rspState <= rspStateNext;
        end
    end

    // Slot is freed when the core acknowledges
    assign rspDone = (rspState == RspWaitAckHigh) && rspAck;

    // Head slot is not rewritten while it is busy, so payload stays stable
    assign rspReq = (rspState == RspWaitAckHigh);
    assign rspTag = tagTable[headPtr];
    assign rspData = dataTable[headPtr];

endmodule

`default_nettype wire

/* hw/MemRequestQueue.sv */
// Request queue of pending memory commands
// Circular buffer with simultaneous push and pop, full and empty status

`timescale 1ns/1ns
`default_nettype none

`include "MemAccess_params.svh"

module MemRequestQueue import MemoryTypes::*; (
    input  logic           clk,
    input  logic           arstN,

    // Push side
    input  logic           pushValid,
    input  MemCommandEntry pushEntry,
    output logic           queueFull,

    // Pop side
    input  logic           pop,
    output MemCommandEntry popEntry,
    output logic           queueEmpty
);

    localparam int unsigned Depth = `MEM_QUEUE_DEPTH;
    localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int unsigned CountWidth = $clog2(Depth + 1);

    MemCommandEntry entries [Depth];

    logic [PtrWidth-1:0] readPtr;
    logic [PtrWidth-1:0] writePtr;
    logic [CountWidth-1:0] count;

    logic doPush;
    logic doPop;

    assign queueFull = (count == CountWidth'(Depth));
    assign queueEmpty = (count == '0);

    // Guard against overflow and underflow at the queue itself
    assign doPush = pushValid && !queueFull;
    assign doPop = pop && !queueEmpty;

    // Head entry, visible one cycle after a push into an empty queue
    assign popEntry = entries[readPtr];

    // Storage
    always_ff @(posedge clk) begin
        if (doPush) begin
            entries[writePtr] <= pushEntry;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            readPtr <= '0;
            writePtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                writePtr <= (writePtr == PtrWidth'(Depth - 1)) ? '0 : writePtr + 1'b1;
            end
            if (doPop) begin
                readPtr <= (readPtr == PtrWidth'(Depth - 1)) ? '0 : readPtr + 1'b1;
            end

            // Push and pop together leave the count unchanged
            case ({doPush, doPop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/MemCommandReceiver.sv */
// Four-phase command port slave
// Accepts one command per req/ack cycle and pushes it into the request queue

`timescale 1ns/1ns
`default_nettype none

`include "MemAccess_params.svh"

module MemCommandReceiver import MemoryTypes::*; (
    input  logic               clk,
    input  logic               arstN,

    // Command port from the core
    input  logic               cmdReq,
    input  logic               cmdWrite,
    input  PhyAddrPath         cmdAddr,
    input  MemoryEntryDataPath cmdData,
    input  MemRequestTag       cmdTag,
    output logic               cmdAck,

    // Push side of the request queue
    input  logic               queueFull,
    output logic               pushValid,
    output MemCommandEntry     pushEntry
);

    // Set once the current request has been pushed
    logic accepted;
    logic acceptNow;
    logic releaseNow;

    // New request, not yet taken, and room in the queue
    assign acceptNow = cmdReq && !accepted && !queueFull;

    // Requester has seen the ack and dropped its request
    assign releaseNow = accepted && !cmdReq;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            accepted <= 1'b0;
        end else if (acceptNow) begin
            accepted <= 1'b1;
        end else if (releaseNow) begin
            accepted <= 1'b0;
        end
    end

    // Ack follows the push by one cycle and holds until req falls
    assign cmdAck = accepted;

    // Single-cycle push in the accept cycle
    assign pushValid = acceptNow;

    // Payload is stable while req is high, so no capture register
    assign pushEntry = {cmdWrite, cmdAddr, cmdData, cmdTag};

endmodule

`default_nettype wire

/* hw/MemoryTypes.sv */
// Package MemoryTypes with the datapath typedefs,
// the queued command entry and the response FSM states

`default_nettype none

`include "MemAccess_params.svh"

package MemoryTypes;

    typedef logic [`MEM_ADDR_WIDTH-1:0] PhyAddrPath;
    typedef logic [`MEM_DATA_WIDTH-1:0] MemoryEntryDataPath;
    typedef logic [`MEM_TAG_WIDTH-1:0] MemRequestTag;

    // Serials handed out by the external memory
    typedef logic [`MEM_SERIAL_WIDTH-1:0] MemAccessSerial;
    typedef logic [`MEM_SERIAL_WIDTH-1:0] MemWriteSerial;

    // Packed as {write, addr, data, tag}, MSB first
    typedef logic [1 + `MEM_ADDR_WIDTH + `MEM_DATA_WIDTH + `MEM_TAG_WIDTH - 1:0]
        MemCommandEntry;

    // Four-phase response port
    typedef enum logic [1:0] {
        RspIdle,
        RspWaitAckHigh,
        RspWaitAckLow
    } AccessCtrlState;

endpackage

`default_nettype wire

/* hw/MemAccess_params.svh */
// Width and depth macros for the memory-access subsystem
// Serial width also fixes the number of reorder slots

`ifndef MEM_ACCESS_PARAMS_SVH
`define MEM_ACCESS_PARAMS_SVH

// Datapath widths
`define MEM_ADDR_WIDTH 16
`define MEM_DATA_WIDTH 32
`define MEM_TAG_WIDTH 4

// 3-bit serials give 8 read slots
`define MEM_SERIAL_WIDTH 3

// Buffering and flow limits
`define MEM_QUEUE_DEPTH 4
`define MAX_PENDING_WRITES 4

`endif
